//--- Makefile
VERILATOR = verilator
FLAGS     = --binary --timing --assert
TOP       = rv_core_tb
FILELIST  = sources.f
OBJ_DIR   = obj_dir
PASS_MSG  = NO ERRORS

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

//--- sim/rv_core_properties.sv
`timescale 1ns/1ps
`default_nettype none

module rv_core_properties import rv_core_pkg::*; (
  input logic     clk,
  input logic     rst_n,
  input logic     mem_req_valid,
  input mem_req_t mem_req,
  input logic     mem_req_ready,
  input logic     mem_rsp_valid,
  input logic     halted
);

  // one request may be outstanding on the bus
  logic outstanding;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      outstanding <= 1'b0;
    end else if (mem_req_valid && mem_req_ready) begin
      outstanding <= 1'b1;
    end else if (mem_rsp_valid) begin
      outstanding <= 1'b0;
    end
  end

  req_stable: assert property (@(posedge clk) disable iff (!rst_n)
    mem_req_valid && !mem_req_ready |=> mem_req_valid && $stable(mem_req))
    else $error("bus request dropped or changed before it was accepted");

  quiet_when_halted: assert property (@(posedge clk) disable iff (!rst_n)
    halted |-> !mem_req_valid)
    else $error("bus request issued while the core is halted");

  rsp_has_request: assert property (@(posedge clk) disable iff (!rst_n)
    mem_rsp_valid |-> outstanding)
    else $error("bus response without an outstanding request");

  // the core waits for the response before the next request
  no_second_request: assert property (@(posedge clk) disable iff (!rst_n)
    outstanding |-> !mem_req_valid)
    else $error("bus request issued while another one is outstanding");

endmodule

bind rv_core_top rv_core_properties u_props (.*);

`default_nettype wire

//--- sim/rv_core_tb.sv
`timescale 1ns/1ps
`default_nettype none

module rv_core_tb import rv_core_pkg::*; ();

  localparam int clk_period   = 40;
  localparam int drive_delay  = 2;
  localparam int reset_cycles = 5;
  localparam int halt_timeout = 2000;
  localparam int drain_cycles = 20;

  logic     clk;
  logic     rst_n = 1'b0;
  logic     mem_req_valid;
  mem_req_t mem_req;
  logic     mem_req_ready = 1'b0;
  logic     mem_rsp_valid = 1'b0;
  mem_rsp_t mem_rsp = '0;
  logic     halted;
  logic     fault;
  logic     illegal;

  // 1 KB of word memory, indexed by addr[9:2]
  word_t    mem [0:255];
  addr_t    exp_addr [$];
  word_t    exp_data [$];
  string    case_name = "none";
  logic     fault_en = 1'b0;
  addr_t    fault_addr = '0;

  int       store_idx = 0;
  int       stores_seen = 0;
  int       store_errors = 0;
  int       errors = 0;
  int       cases_run = 0;

  // pending response of the memory model
  logic     rsp_pend = 1'b0;
  int       rsp_delay = 0;
  mem_rsp_t rsp_next = '0;

  rv_core_top #(.reset_pc(32'h0000_0000)) UUT (
    .clk(clk),
    .rst_n(rst_n),
    .mem_req_valid(mem_req_valid),
    .mem_req(mem_req),
    .mem_req_ready(mem_req_ready),
    .mem_rsp_valid(mem_rsp_valid),
    .mem_rsp(mem_rsp),
    .halted(halted),
    .fault(fault),
    .illegal(illegal)
  );

  initial begin
    clk = 1'b0;
    forever #(clk_period / 2) clk = ~clk;
  end

  task automatic record_store(input addr_t addr, input word_t data);
    stores_seen++;
    if (store_idx >= exp_addr.size()) begin
      $display("%0s: unexpected store of %h to address %h", case_name, data, addr);
      store_errors++;
    end else begin
      if (addr != exp_addr[store_idx]) begin
        $display("CHECK FAILED %0s store %0d address: expected %h, actual %h",
                 case_name, store_idx, exp_addr[store_idx], addr);
        store_errors++;
      end
      if (data != exp_data[store_idx]) begin
        $display("CHECK FAILED %0s store %0d data: expected %h, actual %h",
                 case_name, store_idx, exp_data[store_idx], data);
        store_errors++;
      end
    end
    store_idx++;
  endtask

  // memory model samples at the edge and answers 1 to 3 cycles later
  always @(posedge clk) begin
    logic     fire;
    mem_req_t req;
    fire = rst_n && mem_req_valid && mem_req_ready;
    req  = mem_req;
    #(drive_delay);
    mem_rsp_valid = 1'b0;
    if (!rst_n) begin
      rsp_pend  = 1'b0;
      store_idx = 0;
    end else begin
      if (fire) begin
        rsp_next.err   = fault_en && (req.addr == fault_addr);
        rsp_next.rdata = mem[req.addr[9:2]];
        if (req.write) begin
          record_store(req.addr, req.wdata);
          if (!rsp_next.err) begin
            mem[req.addr[9:2]] = req.wdata;
          end
        end
        rsp_pend  = 1'b1;
        rsp_delay = $urandom_range(2, 0);
      end
      if (rsp_pend) begin
        if (rsp_delay == 0) begin
          mem_rsp_valid = 1'b1;
          mem_rsp       = rsp_next;
          rsp_pend      = 1'b0;
        end else begin
          rsp_delay--;
        end
      end
    end
    mem_req_ready = ($urandom_range(3, 0) != 0);
  end

  task automatic clear_case();
    for (int i = 0; i < 256; i++) begin
      mem[i] = 32'hf00d_0000 | word_t'(i * 4);
    end
    exp_addr.delete();
    exp_data.delete();
    fault_en = 1'b0;
  endtask

  task automatic check_flag(input string flag_name, input logic actual, input logic expected);
    if (actual !== expected) begin
      $display("CHECK FAILED %0s %0s: expected %0b, actual %0b",
               case_name, flag_name, expected, actual);
      errors++;
    end
  endtask

  task automatic run_case(input logic exp_halted, input logic exp_fault, input logic exp_illegal);
    int cycles;
    cases_run++;
    @(posedge clk);
    #(drive_delay);
    rst_n = 1'b0;
    repeat (reset_cycles) @(posedge clk);
    #(drive_delay);
    rst_n = 1'b1;
    cycles = 0;
    while (!halted && cycles < halt_timeout) begin
      @(posedge clk);
      #(drive_delay);
      cycles++;
    end
    if (!halted) begin
      $display("%0s: core did not halt within %0d cycles", case_name, halt_timeout);
      errors++;
    end
    // stores after the halt would still show up here
    cycles = 0;
    while (cycles < drain_cycles) begin
      @(posedge clk);
      cycles++;
    end
    if (store_idx < exp_addr.size()) begin
      $display("%0s: only %0d of %0d expected stores were seen",
               case_name, store_idx, exp_addr.size());
      errors++;
    end
    check_flag("halted", halted, exp_halted);
    check_flag("fault", fault, exp_fault);
    check_flag("illegal", illegal, exp_illegal);
  endtask

  initial begin
    int    fd;
    int    code;
    string tag;
    string rest;
    addr_t a;
    word_t d;
    int    eh;
    int    ef;
    int    ei;
    void'($urandom(32'ha2b98ac9));
    fd = $fopen("sim/store_cases.txt", "r");
    if (fd == 0) begin
      $display("could not open sim/store_cases.txt");
      errors++;
    end else begin
      while (!$feof(fd)) begin
        code = $fscanf(fd, "%s", tag);
        if (code != 1) begin
          tag = "";
        end else if (tag.substr(0, 0) == "#") begin
          code = $fgets(rest, fd);
        end else if (tag == "case") begin
          code = $fscanf(fd, "%s", case_name);
          clear_case();
        end else if (tag == "w") begin
          code = $fscanf(fd, "%h %h", a, d);
          mem[a[9:2]] = d;
        end else if (tag == "f") begin
          code = $fscanf(fd, "%h", a);
          fault_addr = a;
          fault_en   = 1'b1;
        end else if (tag == "s") begin
          code = $fscanf(fd, "%h %h", a, d);
          exp_addr.push_back(a);
          exp_data.push_back(d);
        end else if (tag == "end") begin
          code = $fscanf(fd, "%d %d %d", eh, ef, ei);
          run_case(eh[0], ef[0], ei[0]);
        end else begin
          $display("unknown record %0s in the cases file", tag);
          errors++;
        end
      end
      $fclose(fd);
    end
    if (cases_run == 0) begin
      $display("no cases were run");
      errors++;
    end
    $display("cases run %0d, stores seen %0d, errors %0d",
             cases_run, stores_seen, errors + store_errors);
    if (errors + store_errors == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- sim/store_cases.txt
# records: case <name> | w <addr> <word> | f <fault addr> | s <store addr> <store data>
# end <halted> <fault> <illegal> runs the case; stores are expected in the order listed
case alu_ops
w 00000000 12345137 # lui  x2, 0x12345
w 00000004 67810113 # addi x2, x2, 0x678
w 00000008 ffd00193 # addi x3, x0, -3
w 0000000c 00310233 # add  x4, x2, x3
w 00000010 30402023 # sw   x4, 0x300(x0)
w 00000014 40218233 # sub  x4, x3, x2
w 00000018 30402223 # sw   x4, 0x304(x0)
w 0000001c 00317233 # and  x4, x2, x3
w 00000020 30402423 # sw   x4, 0x308(x0)
w 00000024 00316233 # or   x4, x2, x3
w 00000028 30402623 # sw   x4, 0x30c(x0)
w 0000002c 00314233 # xor  x4, x2, x3
w 00000030 30402823 # sw   x4, 0x310(x0)
w 00000034 0021a233 # slt  x4, x3, x2
w 00000038 30402a23 # sw   x4, 0x314(x0)
w 0000003c 30202c23 # sw   x2, 0x318(x0)
w 00000040 00100073 # ebreak
s 00000300 12345675
s 00000304 edcba985
s 00000308 12345678
s 0000030c fffffffd
s 00000310 edcba985
s 00000314 00000001
s 00000318 12345678
end 1 0 0

case load_store
w 00000000 1ab00293 # addi x5, x0, 0x1ab
w 00000004 32502023 # sw   x5, 0x320(x0)
w 00000008 32002303 # lw   x6, 0x320(x0)
w 0000000c 01130313 # addi x6, x6, 0x11
w 00000010 32602223 # sw   x6, 0x324(x0)
w 00000014 32802383 # lw   x7, 0x328(x0)
w 00000018 32702623 # sw   x7, 0x32c(x0)
w 0000001c 00100073 # ebreak
w 00000328 cafef00d # preloaded data word
s 00000320 000001ab
s 00000324 000001bc
s 0000032c cafef00d
end 1 0 0

case branch_jal
w 00000000 00500093 # addi x1, x0, 5
w 00000004 00500113 # addi x2, x0, 5
w 00000008 00208463 # beq  x1, x2, +8 taken
w 0000000c 34102023 # sw   x1, 0x340(x0) skipped
w 00000010 00209463 # bne  x1, x2, +8 not taken
w 00000014 34202223 # sw   x2, 0x344(x0)
w 00000018 00700193 # addi x3, x0, 7
w 0000001c 00309463 # bne  x1, x3, +8 taken
w 00000020 34302423 # sw   x3, 0x348(x0) skipped
w 00000024 00308463 # beq  x1, x3, +8 not taken
w 00000028 0080026f # jal  x4, +8
w 0000002c 34102623 # sw   x1, 0x34c(x0) skipped
w 00000030 34402823 # sw   x4, 0x350(x0)
w 00000034 00100073 # ebreak
s 00000344 00000005
s 00000350 0000002c
end 1 0 0

case x0_zero
w 00000000 05500013 # addi x0, x0, 0x55
w 00000004 abcde037 # lui  x0, 0xabcde
w 00000008 36002023 # sw   x0, 0x360(x0)
w 0000000c 00100073 # ebreak
w 00000010 36002223 # sw   x0, 0x364(x0) after the halt
s 00000360 00000000
end 1 0 0

case illegal_zero
w 00000000 00900093 # addi x1, x0, 9
w 00000004 36102823 # sw   x1, 0x370(x0)
w 00000008 00000000 # all-zero word traps
w 0000000c 36102a23 # sw   x1, 0x374(x0) after the trap
w 00000010 00100073 # ebreak
s 00000370 00000009
end 1 0 1

case load_fault
f 00000380
w 00000000 00300093 # addi x1, x0, 3
w 00000004 38102223 # sw   x1, 0x384(x0)
w 00000008 38002103 # lw   x2, 0x380(x0) faults
w 0000000c 38202423 # sw   x2, 0x388(x0) after the fault
w 00000010 00100073 # ebreak
s 00000384 00000003
end 1 1 0

//--- sources.f
verilog/rv_core_pkg.sv
verilog/reg_file.sv
verilog/fetch_unit.sv
verilog/decode_unit.sv
verilog/exec_unit.sv
verilog/load_store_unit.sv
verilog/mem_arbiter.sv
verilog/rv_core_top.sv
sim/rv_core_properties.sv
sim/rv_core_tb.sv

//--- verilog/decode_unit.sv
`timescale 1ns/1ps
`default_nettype none

module decode_unit import rv_core_pkg::*; (
  input  logic       fetch_valid,
  output logic       fetch_ready,
  input  fetch_pkt_t fetch_pkt,
  output reg_idx_t   raddr1,
  output reg_idx_t   raddr2,
  input  word_t      rdata1,
  input  word_t      rdata2,
  output logic       dec_valid,
  input  logic       dec_ready,
  output dec_pkt_t   dec_pkt
);

  word_t      inst;
  opcode_t    opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  word_t      imm_i;
  word_t      imm_s;
  word_t      imm_b;
  word_t      imm_j;
  word_t      imm_u;

  assign inst   = fetch_pkt.inst;
  assign opcode = opcode_t'(inst[6:0]);
  assign funct3 = inst[14:12];
  assign funct7 = inst[31:25];
  assign raddr1 = inst[19:15];
  assign raddr2 = inst[24:20];

  assign imm_i = {{20{inst[31]}}, inst[31:20]};
  assign imm_s = {{20{inst[31]}}, inst[31:25], inst[11:7]};
  assign imm_b = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
  assign imm_j = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};
  assign imm_u = {inst[31:12], 12'b0};

  // no state here, so the handshake passes straight through
  assign dec_valid   = fetch_valid;
  assign fetch_ready = dec_ready;

  always_comb begin
    dec_pkt.pc        = fetch_pkt.pc;
    dec_pkt.kind      = op_illegal;
    dec_pkt.alu_op    = alu_add;
    dec_pkt.operand_a = rdata1;
    dec_pkt.operand_b = rdata2;
    dec_pkt.rs2_val   = rdata2;
    dec_pkt.imm       = imm_i;
    dec_pkt.rd        = inst[11:7];
    case (opcode)
      opc_lui: begin
        dec_pkt.kind      = op_alu;
        dec_pkt.alu_op    = alu_pass_b;
        dec_pkt.operand_b = imm_u;
        dec_pkt.imm       = imm_u;
      end
      opc_op_imm: begin
        // addi only
        if (funct3 == 3'b000) begin
          dec_pkt.kind      = op_alu;
          dec_pkt.operand_b = imm_i;
        end
      end
      opc_op: begin
        if (funct7 == 7'b0100000 && funct3 == 3'b000) begin
          dec_pkt.kind   = op_alu;
          dec_pkt.alu_op = alu_sub;
        end else if (funct7 == 7'b0000000) begin
          dec_pkt.kind = op_alu;
          case (funct3)
            3'b000:  dec_pkt.alu_op = alu_add;
            3'b010:  dec_pkt.alu_op = alu_slt;
            3'b100:  dec_pkt.alu_op = alu_xor;
            3'b110:  dec_pkt.alu_op = alu_or;
            3'b111:  dec_pkt.alu_op = alu_and;
            default: dec_pkt.kind   = op_illegal;
          endcase
        end
      end
      opc_load: begin
        if (funct3 == 3'b010) begin
          dec_pkt.kind      = op_load;
          dec_pkt.operand_b = imm_i;
        end
      end
      opc_store: begin
        if (funct3 == 3'b010) begin
          dec_pkt.kind      = op_store;
          dec_pkt.operand_b = imm_s;
          dec_pkt.imm       = imm_s;
        end
      end
      opc_branch: begin
        dec_pkt.imm = imm_b;
        if (funct3 == 3'b000) begin
          dec_pkt.kind = op_branch_eq;
        end else if (funct3 == 3'b001) begin
          dec_pkt.kind = op_branch_ne;
        end
      end
      opc_jal: begin
        dec_pkt.kind = op_jal;
        dec_pkt.imm  = imm_j;
      end
      opc_system: begin
        if (inst == inst_ebreak) begin
          dec_pkt.kind = op_halt;
        end
      end
      default: dec_pkt.kind = op_illegal;
    endcase
  end

endmodule

`default_nettype wire

//--- verilog/exec_unit.sv
`timescale 1ns/1ps
`default_nettype none

module exec_unit import rv_core_pkg::*; (
  input  logic     clk,
  input  logic     rst_n,
  input  logic     dec_valid,
  output logic     dec_ready,
  input  dec_pkt_t dec_pkt,
  output logic     npc_valid,
  output addr_t    npc,
  output logic     wen,
  output reg_idx_t waddr,
  output word_t    wdata,
  output logic     lsu_valid,
  input  logic     lsu_ready,
  output lsu_req_t lsu_req,
  input  logic     lsu_done,
  input  word_t    lsu_rdata,
  input  logic     lsu_err,
  output logic     halted,
  output logic     fault,
  output logic     illegal
);

  typedef enum logic [1:0] {e_idle, e_mem, e_wb, e_stopped} exec_state_t;

  exec_state_t state;
  logic        req_pend;
  logic        wb_en;
  word_t       alu_result;
  logic        take_target;
  addr_t       pc_plus4;
  addr_t       next_pc;

  assign dec_ready = (state == e_idle);
  assign lsu_valid = (state == e_mem) && req_pend;
  assign npc_valid = (state == e_wb);
  assign wen       = (state == e_wb) && wb_en;

  always_comb begin
    case (dec_pkt.alu_op)
      alu_add:    alu_result = dec_pkt.operand_a + dec_pkt.operand_b;
      alu_sub:    alu_result = dec_pkt.operand_a - dec_pkt.operand_b;
      alu_and:    alu_result = dec_pkt.operand_a & dec_pkt.operand_b;
      alu_or:     alu_result = dec_pkt.operand_a | dec_pkt.operand_b;
      alu_xor:    alu_result = dec_pkt.operand_a ^ dec_pkt.operand_b;
      alu_slt:    alu_result = {31'b0, $signed(dec_pkt.operand_a) < $signed(dec_pkt.operand_b)};
      alu_pass_b: alu_result = dec_pkt.operand_b;
      default:    alu_result = dec_pkt.operand_a + dec_pkt.operand_b;
    endcase
  end

  // branch compare uses rs1 against rs2
  always_comb begin
    case (dec_pkt.kind)
      op_branch_eq: take_target = (dec_pkt.operand_a == dec_pkt.rs2_val);
      op_branch_ne: take_target = (dec_pkt.operand_a != dec_pkt.rs2_val);
      op_jal:       take_target = 1'b1;
      default:      take_target = 1'b0;
    endcase
  end

  assign pc_plus4 = dec_pkt.pc + 32'd4;
  assign next_pc  = take_target ? dec_pkt.pc + dec_pkt.imm : pc_plus4;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state    <= e_idle;
      req_pend <= 1'b0;
      wb_en    <= 1'b0;
      halted   <= 1'b0;
      fault    <= 1'b0;
      illegal  <= 1'b0;
    end else begin
      case (state)
        e_idle: begin
          if (dec_valid) begin
            case (dec_pkt.kind)
              op_load, op_store: begin
                state    <= e_mem;
                req_pend <= 1'b1;
                wb_en    <= (dec_pkt.kind == op_load);
              end
              op_halt: begin
                halted <= 1'b1;
                state  <= e_stopped;
              end
              op_illegal: begin
                halted  <= 1'b1;
                illegal <= 1'b1;
                state   <= e_stopped;
              end
              default: begin
                state <= e_wb;
                wb_en <= (dec_pkt.kind == op_alu) || (dec_pkt.kind == op_jal);
              end
            endcase
          end
        end
        e_mem: begin
          if (lsu_valid && lsu_ready) begin
            req_pend <= 1'b0;
          end
          if (lsu_done) begin
            if (lsu_err) begin
              fault  <= 1'b1;
              halted <= 1'b1;
              state  <= e_stopped;
            end else begin
              state <= e_wb;
            end
          end
        end
        e_wb:    state <= e_idle;
        default: state <= e_stopped;
      endcase
    end
  end

  // result, target and memory op captured on accept
  always_ff @(posedge clk) begin
    if (state == e_idle && dec_valid) begin
      waddr         <= dec_pkt.rd;
      wdata         <= (dec_pkt.kind == op_jal) ? pc_plus4 : alu_result;
      npc           <= next_pc;
      lsu_req.write <= (dec_pkt.kind == op_store);
      lsu_req.addr  <= alu_result;
      lsu_req.wdata <= dec_pkt.rs2_val;
    end else if (state == e_mem && lsu_done) begin
      wdata <= lsu_rdata;
    end
  end

endmodule

`default_nettype wire

//--- verilog/fetch_unit.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_unit import rv_core_pkg::*; #(
  parameter addr_t reset_pc = '0
) (
  input  logic       clk,
  input  logic       rst_n,
  input  logic       npc_valid,
  input  addr_t      npc,
  output logic       fetch_valid,
  input  logic       fetch_ready,
  output fetch_pkt_t fetch_pkt,
  output logic       req_valid,
  output mem_req_t   req,
  input  logic       req_ready,
  input  logic       rsp_valid,
  input  mem_rsp_t   rsp
);

  typedef enum logic [1:0] {f_idle, f_req, f_wait, f_hold} fetch_state_t;

  fetch_state_t state;
  addr_t        pc;

  assign req_valid   = (state == f_req);
  assign req.write   = 1'b0;
  assign req.addr    = pc;
  assign req.wdata   = '0;
  assign fetch_valid = (state == f_hold);

  // first request goes out right after reset
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state <= f_req;
      pc    <= reset_pc;
    end else begin
      case (state)
        f_idle: begin
          if (npc_valid) begin
            pc    <= npc;
            state <= f_req;
          end
        end
        f_req: begin
          if (req_ready) begin
            state <= f_wait;
          end
        end
        f_wait: begin
          if (rsp_valid) begin
            state <= f_hold;
          end
        end
        default: begin
          if (fetch_ready) begin
            state <= f_idle;
          end
        end
      endcase
    end
  end

  // a failed fetch hands decode a zero word, which traps as illegal
  always_ff @(posedge clk) begin
    if (state == f_wait && rsp_valid) begin
      fetch_pkt.pc   <= pc;
      fetch_pkt.inst <= rsp.err ? '0 : rsp.rdata;
    end
  end

endmodule

`default_nettype wire

//--- verilog/load_store_unit.sv
`timescale 1ns/1ps
`default_nettype none

module load_store_unit import rv_core_pkg::*; (
  input  logic     clk,
  input  logic     rst_n,
  input  logic     lsu_valid,
  output logic     lsu_ready,
  input  lsu_req_t lsu_req,
  output logic     lsu_done,
  output word_t    lsu_rdata,
  output logic     lsu_err,
  output logic     req_valid,
  output mem_req_t req,
  input  logic     req_ready,
  input  logic     rsp_valid,
  input  mem_rsp_t rsp
);

  typedef enum logic [1:0] {l_idle, l_req, l_wait} lsu_state_t;

  lsu_state_t state;

  assign lsu_ready = (state == l_idle);
  assign req_valid = (state == l_req);

  // the response is handed back in the cycle it arrives
  assign lsu_done  = (state == l_wait) && rsp_valid;
  assign lsu_rdata = rsp.rdata;
  assign lsu_err   = rsp.err;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state <= l_idle;
    end else begin
      case (state)
        l_idle:  if (lsu_valid) state <= l_req;
        l_req:   if (req_ready) state <= l_wait;
        l_wait:  if (rsp_valid) state <= l_idle;
        default: state <= l_idle;
      endcase
    end
  end

  // bus payload held stable until granted
  always_ff @(posedge clk) begin
    if (lsu_valid && lsu_ready) begin
      req.write <= lsu_req.write;
      req.addr  <= lsu_req.addr;
      req.wdata <= lsu_req.wdata;
    end
  end

endmodule

`default_nettype wire

//--- verilog/mem_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

module mem_arbiter import rv_core_pkg::*; (
  input  logic     clk,
  input  logic     rst_n,
  input  logic     ifu_req_valid,
  input  mem_req_t ifu_req,
  output logic     ifu_req_ready,
  output logic     ifu_rsp_valid,
  input  logic     lsu_req_valid,
  input  mem_req_t lsu_req,
  output logic     lsu_req_ready,
  output logic     lsu_rsp_valid,
  output logic     mem_req_valid,
  output mem_req_t mem_req,
  input  logic     mem_req_ready,
  input  logic     mem_rsp_valid,
  input  mem_rsp_t mem_rsp,
  output mem_rsp_t mem_rsp_out
);

  logic busy;
  // set when load/store owns the outstanding request
  logic owner_lsu;

  assign mem_req_valid = !busy && (lsu_req_valid || ifu_req_valid);
  assign mem_req       = lsu_req_valid ? lsu_req : ifu_req;
  assign lsu_req_ready = !busy && mem_req_ready;
  assign ifu_req_ready = !busy && !lsu_req_valid && mem_req_ready;

  assign ifu_rsp_valid = mem_rsp_valid && busy && !owner_lsu;
  assign lsu_rsp_valid = mem_rsp_valid && busy && owner_lsu;
  assign mem_rsp_out   = mem_rsp;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      busy      <= 1'b0;
      owner_lsu <= 1'b0;
    end else if (mem_req_valid && mem_req_ready) begin
      busy      <= 1'b1;
      owner_lsu <= lsu_req_valid;
    end else if (mem_rsp_valid) begin
      busy <= 1'b0;
    end
  end

endmodule

`default_nettype wire

//--- verilog/reg_file.sv
`timescale 1ns/1ps
`default_nettype none

module reg_file import rv_core_pkg::*; (
  input  logic     clk,
  input  logic     rst_n,
  input  reg_idx_t raddr1,
  output word_t    rdata1,
  input  reg_idx_t raddr2,
  output word_t    rdata2,
  input  logic     wen,
  input  reg_idx_t waddr,
  input  word_t    wdata
);

  // x0 has no storage
  word_t regs [1:31];

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 1; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (wen && waddr != '0) begin
      regs[waddr] <= wdata;
    end
  end

  assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];
  assign rdata2 = (raddr2 == '0) ? '0 : regs[raddr2];

endmodule

`default_nettype wire

//--- verilog/rv_core_pkg.sv
`default_nettype none

package rv_core_pkg;

  typedef logic [31:0] word_t;
  typedef logic [31:0] addr_t;
  typedef logic [4:0]  reg_idx_t;

  // major opcodes of the supported subset
  typedef enum logic [6:0] {
    opc_lui    = 7'b0110111,
    opc_op_imm = 7'b0010011,
    opc_op     = 7'b0110011,
    opc_load   = 7'b0000011,
    opc_store  = 7'b0100011,
    opc_branch = 7'b1100011,
    opc_jal    = 7'b1101111,
    opc_system = 7'b1110011
  } opcode_t;

  localparam word_t inst_ebreak = 32'h0010_0073;

  typedef enum logic [2:0] {
    alu_add, alu_sub, alu_and, alu_or, alu_xor, alu_slt, alu_pass_b
  } alu_op_t;

  typedef enum logic [2:0] {
    op_alu, op_load, op_store, op_branch_eq, op_branch_ne, op_jal, op_halt, op_illegal
  } op_kind_t;

  typedef struct packed {
    addr_t pc;
    word_t inst;
  } fetch_pkt_t;

  typedef struct packed {
    addr_t    pc;
    op_kind_t kind;
    alu_op_t  alu_op;
    word_t    operand_a;
    word_t    operand_b;
    word_t    rs2_val;
    word_t    imm;
    reg_idx_t rd;
  } dec_pkt_t;

  typedef struct packed {
    logic  write;
    addr_t addr;
    word_t wdata;
  } lsu_req_t;

  typedef struct packed {
    logic  write;
    addr_t addr;
    word_t wdata;
  } mem_req_t;

  typedef struct packed {
    word_t rdata;
    logic  err;
  } mem_rsp_t;

endpackage

`default_nettype wire

//--- verilog/rv_core_top.sv
`timescale 1ns/1ps
`default_nettype none

module rv_core_top import rv_core_pkg::*; #(
  parameter addr_t reset_pc = '0
) (
  input  logic     clk,
  input  logic     rst_n,
  output logic     mem_req_valid,
  output mem_req_t mem_req,
  input  logic     mem_req_ready,
  input  logic     mem_rsp_valid,
  input  mem_rsp_t mem_rsp,
  output logic     halted,
  output logic     fault,
  output logic     illegal
);

  logic       fetch_valid;
  logic       fetch_ready;
  fetch_pkt_t fetch_pkt;
  reg_idx_t   raddr1;
  reg_idx_t   raddr2;
  word_t      rdata1;
  word_t      rdata2;
  logic       dec_valid;
  logic       dec_ready;
  dec_pkt_t   dec_pkt;
  logic       npc_valid;
  addr_t      npc;
  logic       wen;
  reg_idx_t   waddr;
  word_t      wdata;
  logic       lsu_valid;
  logic       lsu_ready;
  lsu_req_t   lsu_req;
  logic       lsu_done;
  word_t      lsu_rdata;
  logic       lsu_err;

  // arbiter client ports
  logic       ifu_req_valid;
  mem_req_t   ifu_req;
  logic       ifu_req_ready;
  logic       ifu_rsp_valid;
  logic       lsu_mem_req_valid;
  mem_req_t   lsu_mem_req;
  logic       lsu_mem_req_ready;
  logic       lsu_mem_rsp_valid;
  mem_rsp_t   shared_rsp;

  fetch_unit #(.reset_pc(reset_pc)) u_fetch (
    .clk(clk), .rst_n(rst_n),
    .npc_valid(npc_valid), .npc(npc),
    .fetch_valid(fetch_valid), .fetch_ready(fetch_ready), .fetch_pkt(fetch_pkt),
    .req_valid(ifu_req_valid), .req(ifu_req), .req_ready(ifu_req_ready),
    .rsp_valid(ifu_rsp_valid), .rsp(shared_rsp)
  );

  decode_unit u_decode (
    .fetch_valid(fetch_valid), .fetch_ready(fetch_ready), .fetch_pkt(fetch_pkt),
    .raddr1(raddr1), .raddr2(raddr2), .rdata1(rdata1), .rdata2(rdata2),
    .dec_valid(dec_valid), .dec_ready(dec_ready), .dec_pkt(dec_pkt)
  );

  exec_unit u_exec (
    .clk(clk), .rst_n(rst_n),
    .dec_valid(dec_valid), .dec_ready(dec_ready), .dec_pkt(dec_pkt),
    .npc_valid(npc_valid), .npc(npc),
    .wen(wen), .waddr(waddr), .wdata(wdata),
    .lsu_valid(lsu_valid), .lsu_ready(lsu_ready), .lsu_req(lsu_req),
    .lsu_done(lsu_done), .lsu_rdata(lsu_rdata), .lsu_err(lsu_err),
    .halted(halted), .fault(fault), .illegal(illegal)
  );

  reg_file u_regs (
    .clk(clk), .rst_n(rst_n),
    .raddr1(raddr1), .rdata1(rdata1),
    .raddr2(raddr2), .rdata2(rdata2),
    .wen(wen), .waddr(waddr), .wdata(wdata)
  );

  load_store_unit u_lsu (
    .clk(clk), .rst_n(rst_n),
    .lsu_valid(lsu_valid), .lsu_ready(lsu_ready), .lsu_req(lsu_req),
    .lsu_done(lsu_done), .lsu_rdata(lsu_rdata), .lsu_err(lsu_err),
    .req_valid(lsu_mem_req_valid), .req(lsu_mem_req), .req_ready(lsu_mem_req_ready),
    .rsp_valid(lsu_mem_rsp_valid), .rsp(shared_rsp)
  );

  mem_arbiter u_arb (
    .clk(clk), .rst_n(rst_n),
    .ifu_req_valid(ifu_req_valid), .ifu_req(ifu_req),
    .ifu_req_ready(ifu_req_ready), .ifu_rsp_valid(ifu_rsp_valid),
    .lsu_req_valid(lsu_mem_req_valid), .lsu_req(lsu_mem_req),
    .lsu_req_ready(lsu_mem_req_ready), .lsu_rsp_valid(lsu_mem_rsp_valid),
    .mem_req_valid(mem_req_valid), .mem_req(mem_req), .mem_req_ready(mem_req_ready),
    .mem_rsp_valid(mem_rsp_valid), .mem_rsp(mem_rsp), .mem_rsp_out(shared_rsp)
  );

endmodule

`default_nettype wire
